// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module tb_stopwatch \
  -o sim_stopwatch

./obj_dir/sim_stopwatch | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== stopwatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stopwatch #(
  parameter int unsigned tick_div = `STW_TICK_DIV
) (
  input  logic                  clk100_i,
  input  logic                  rstn_i,
  input  logic                  start_stop_i,
  input  logic                  set_i,
  input  logic                  change_i,
  output logic [`STW_SEG_W-1:0] hex0_o,
  output logic [`STW_SEG_W-1:0] hex1_o,
  output logic [`STW_SEG_W-1:0] hex2_o,
  output logic [`STW_SEG_W-1:0] hex3_o
);

  logic                 start_stop_press;
  logic                 set_press;
  logic                 change_press;
  stw_pkg::stw_ctrl_t   ctrl;
  stw_pkg::stw_digits_t digits;

  // ####################
  // buttons
  // ####################
  stw_button_sync u_sync_start_stop (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_i    (start_stop_i),
    .press_o  (start_stop_press)
  );

  stw_button_sync u_sync_set (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_i    (set_i),
    .press_o  (set_press)
  );

  stw_button_sync u_sync_change (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_i    (change_i),
    .press_o  (change_press)
  );

  // ####################
  // datapath
  // ####################
  stw_control u_control (
    .clk100_i           (clk100_i),
    .rstn_i             (rstn_i),
    .start_stop_press_i (start_stop_press),
    .set_press_i        (set_press),
    .change_press_i     (change_press),
    .ctrl_o             (ctrl)
  );

  stw_time_counter #(
    .tick_div (tick_div)
  ) u_time_counter (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .ctrl_i   (ctrl),
    .digits_o (digits)
  );

  stw_seg_display u_seg_display (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .digits_i (digits),
    .hex0_o   (hex0_o),
    .hex1_o   (hex1_o),
    .hex2_o   (hex2_o),
    .hex3_o   (hex3_o)
  );

endmodule

`default_nettype wire

// ==== stopwatch_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stopwatch_props (
  input logic                  clk100_i,
  input logic                  rstn_i,
  input logic                  start_stop_i,
  input logic                  start_stop_press_i,
  input logic                  set_press_i,
  input logic                  change_press_i,
  input stw_pkg::stw_mode_e    mode_i,
  input stw_pkg::stw_ctrl_t    ctrl_i,
  input stw_pkg::stw_digits_t  digits_i,
  input logic [`STW_SEG_W-1:0] hex0_i,
  input logic [`STW_SEG_W-1:0] hex1_i,
  input logic [`STW_SEG_W-1:0] hex2_i,
  input logic [`STW_SEG_W-1:0] hex3_i
);

  localparam logic [`STW_SEG_W-1:0] SEG_ZERO = 7'b0000001;

  // ####################
  // press strobes
  // ####################
  start_stop_one_cycle: assert property (@(posedge clk100_i) disable iff (rstn_i)
    start_stop_press_i |=> !start_stop_press_i) else $error("start/stop strobe too long");
  set_one_cycle: assert property (@(posedge clk100_i) disable iff (rstn_i)
    set_press_i |=> !set_press_i) else $error("set strobe too long");
  change_one_cycle: assert property (@(posedge clk100_i) disable iff (rstn_i)
    change_press_i |=> !change_press_i) else $error("change strobe too long");
  start_stop_latency: assert property (@(posedge clk100_i) disable iff (rstn_i)
    start_stop_press_i |-> $past(start_stop_i, `STW_SYNC_STAGES))
    else $error("start/stop strobe without earlier button level");

  // ####################
  // control and counter
  // ####################
  no_count_in_set: assert property (@(posedge clk100_i) disable iff (rstn_i)
    (mode_i != stw_pkg::MODE_IDLE) |-> !ctrl_i.count_en) else $error("counting outside idle");
  digits_in_limit: assert property (@(posedge clk100_i) disable iff (rstn_i)
    (digits_i.d0 <= ctrl_i.limits.d0) && (digits_i.d1 <= ctrl_i.limits.d1) &&
    (digits_i.d2 <= ctrl_i.limits.d2) && (digits_i.d3 <= ctrl_i.limits.d3))
    else $error("digit above its limit");
  zero_in_reset: assert property (@(posedge clk100_i) (rstn_i && $past(rstn_i)) |->
    (hex0_i == SEG_ZERO) && (hex1_i == SEG_ZERO) && (hex2_i == SEG_ZERO) && (hex3_i == SEG_ZERO))
    else $error("segments not zero during reset");

endmodule

bind stopwatch stopwatch_props u_props (
  .clk100_i           (clk100_i),
  .rstn_i             (rstn_i),
  .start_stop_i       (start_stop_i),
  .start_stop_press_i (start_stop_press),
  .set_press_i        (set_press),
  .change_press_i     (change_press),
  .mode_i             (u_control.mode_q),
  .ctrl_i             (ctrl),
  .digits_i           (digits),
  .hex0_i             (hex0_o),
  .hex1_i             (hex1_o),
  .hex2_i             (hex2_o),
  .hex3_i             (hex3_o)
);

`default_nettype wire

// ==== stw_button_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stw_button_sync (
  input  logic clk100_i,
  input  logic rstn_i,
  input  logic btn_i,
  output logic press_o
);

  localparam int unsigned STAGES = `STW_SYNC_STAGES;

  logic [STAGES-1:0] sync_q;  // bit 0 is the newest sample
  logic              rise;

  // rising edge between the two oldest stages
  assign rise = sync_q[STAGES-2] & ~sync_q[STAGES-1];

  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      sync_q  <= '0;
      press_o <= 1'b0;
    end else begin
      sync_q  <= {sync_q[STAGES-2:0], btn_i};
      press_o <= rise;  // one cycle strobe
    end
  end

endmodule

`default_nettype wire

// ==== stw_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stw_control (
  input  logic                clk100_i,
  input  logic                rstn_i,
  input  logic                start_stop_press_i,
  input  logic                set_press_i,
  input  logic                change_press_i,
  output stw_pkg::stw_ctrl_t  ctrl_o
);

  stw_pkg::stw_mode_e   mode_q;
  stw_pkg::stw_mode_e   mode_d;
  stw_pkg::stw_digits_t limits_q;
  logic                 run_q;

  // next decimal limit, 9 rolls over to 0
  function automatic logic [`STW_BCD_W-1:0] bcd_inc(input logic [`STW_BCD_W-1:0] val);
    logic [`STW_BCD_W-1:0] res;
    if (val >= `STW_BCD_W'd9) begin
      res = '0;
    end else begin
      res = val + 1'b1;
    end
    return res;
  endfunction

  // ####################
  // set-mode FSM
  // ####################
  always_comb begin
    mode_d = mode_q;
    if (set_press_i) begin
      unique case (mode_q)
        stw_pkg::MODE_IDLE:   mode_d = stw_pkg::MODE_SET_D0;
        stw_pkg::MODE_SET_D0: mode_d = stw_pkg::MODE_SET_D1;
        stw_pkg::MODE_SET_D1: mode_d = stw_pkg::MODE_SET_D2;
        stw_pkg::MODE_SET_D2: mode_d = stw_pkg::MODE_SET_D3;
        stw_pkg::MODE_SET_D3: mode_d = stw_pkg::MODE_IDLE;
        default:              mode_d = stw_pkg::MODE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      mode_q <= stw_pkg::MODE_IDLE;
    end else begin
      mode_q <= mode_d;
    end
  end

  // ####################
  // run flag and limits
  // ####################
  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      run_q <= 1'b0;
    end else if (start_stop_press_i && (mode_q == stw_pkg::MODE_IDLE)) begin
      run_q <= ~run_q;  // ignored while editing
    end
  end

  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      limits_q.d0 <= `STW_BCD_W'd9;
      limits_q.d1 <= `STW_BCD_W'd9;
      limits_q.d2 <= `STW_BCD_W'd9;
      limits_q.d3 <= `STW_BCD_W'd9;
    end else if (change_press_i) begin
      case (mode_q)
        stw_pkg::MODE_SET_D0: limits_q.d0 <= bcd_inc(limits_q.d0);
        stw_pkg::MODE_SET_D1: limits_q.d1 <= bcd_inc(limits_q.d1);
        stw_pkg::MODE_SET_D2: limits_q.d2 <= bcd_inc(limits_q.d2);
        stw_pkg::MODE_SET_D3: limits_q.d3 <= bcd_inc(limits_q.d3);
        default: ;  // idle, change has no effect
      endcase
    end
  end

  assign ctrl_o.count_en = run_q && (mode_q == stw_pkg::MODE_IDLE);
  assign ctrl_o.limits   = limits_q;

endmodule

`default_nettype wire

// ==== stw_params.svh ====
`ifndef STW_PARAMS_SVH
`define STW_PARAMS_SVH

// ####################
// widths
// ####################
`define STW_BCD_W 4  // one decimal digit
`define STW_SEG_W 7  // a..g, bit 6 is a

// ####################
// timing
// ####################
`define STW_SYNC_STAGES 3  // button synchronizer depth

// clocks per hundredth of a second at 100 MHz
`define STW_TICK_DIV 1000000

`endif

// ==== stw_pkg.sv ====
`default_nettype none

`include "stw_params.svh"

package stw_pkg;

  // ####################
  // control mode
  // ####################
  typedef enum logic [2:0] {
    MODE_IDLE   = 3'd0,  // normal operation, counting allowed
    MODE_SET_D0 = 3'd1,  // editing hundredths limit
    MODE_SET_D1 = 3'd2,  // tenths
    MODE_SET_D2 = 3'd3,  // seconds
    MODE_SET_D3 = 3'd4   // tens of seconds
  } stw_mode_e;

  // ####################
  // shared structs
  // ####################
  typedef struct packed {
    logic [`STW_BCD_W-1:0] d3;  // tens of seconds
    logic [`STW_BCD_W-1:0] d2;  // seconds
    logic [`STW_BCD_W-1:0] d1;  // tenths
    logic [`STW_BCD_W-1:0] d0;  // hundredths
  } stw_digits_t;

  // control block to time counter
  typedef struct packed {
    logic        count_en;  // run flag gated by idle mode
    stw_digits_t limits;    // per-digit wrap value
  } stw_ctrl_t;

endpackage

`default_nettype wire

// ==== stw_seg_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stw_seg_display (
  input  logic                  clk100_i,
  input  logic                  rstn_i,
  input  stw_pkg::stw_digits_t  digits_i,
  output logic [`STW_SEG_W-1:0] hex0_o,
  output logic [`STW_SEG_W-1:0] hex1_o,
  output logic [`STW_SEG_W-1:0] hex2_o,
  output logic [`STW_SEG_W-1:0] hex3_o
);

  localparam logic [`STW_SEG_W-1:0] SEG_ZERO = 7'b0000001;

  // active low, bit 6 = a ... bit 0 = g
  function automatic logic [`STW_SEG_W-1:0] seg_decode(input logic [`STW_BCD_W-1:0] bcd);
    logic [`STW_SEG_W-1:0] seg;
    case (bcd)
      4'd0:    seg = SEG_ZERO;
      4'd1:    seg = 7'b1001111;
      4'd2:    seg = 7'b0010010;
      4'd3:    seg = 7'b0000110;
      4'd4:    seg = 7'b1001100;
      4'd5:    seg = 7'b0100100;
      4'd6:    seg = 7'b0100000;
      4'd7:    seg = 7'b0001111;
      4'd8:    seg = 7'b0000000;
      4'd9:    seg = 7'b0000100;
      default: seg = 7'b1111111;  // blank
    endcase
    return seg;
  endfunction

  // registered so carries never reach the pins
  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      hex0_o <= SEG_ZERO;
      hex1_o <= SEG_ZERO;
      hex2_o <= SEG_ZERO;
      hex3_o <= SEG_ZERO;
    end else begin
      hex0_o <= seg_decode(digits_i.d0);
      hex1_o <= seg_decode(digits_i.d1);
      hex2_o <= seg_decode(digits_i.d2);
      hex3_o <= seg_decode(digits_i.d3);
    end
  end

endmodule

`default_nettype wire

// ==== stw_time_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module stw_time_counter #(
  parameter int unsigned tick_div = `STW_TICK_DIV
) (
  input  logic                 clk100_i,
  input  logic                 rstn_i,
  input  stw_pkg::stw_ctrl_t   ctrl_i,
  output stw_pkg::stw_digits_t digits_o
);

  localparam int unsigned NUM_DIGITS = 4;
  localparam int unsigned PRESC_W    = (tick_div > 1) ? $clog2(tick_div) : 1;

  logic [PRESC_W-1:0]                   presc_q;
  logic                                 tick;
  logic [NUM_DIGITS-1:0][`STW_BCD_W-1:0] dig_q;
  logic [NUM_DIGITS-1:0][`STW_BCD_W-1:0] dig_d;
  logic [NUM_DIGITS-1:0][`STW_BCD_W-1:0] lim;
  logic [NUM_DIGITS-1:0]                carry;  // increment request into each digit
  logic [NUM_DIGITS-1:0]                wrap;

  // ####################
  // prescaler
  // ####################
  assign tick = ctrl_i.count_en && (presc_q == PRESC_W'(tick_div - 1));

  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      presc_q <= '0;
    end else if (ctrl_i.count_en) begin
      if (tick) begin
        presc_q <= '0;
      end else begin
        presc_q <= presc_q + 1'b1;
      end
    end
  end

  // ####################
  // digit chain
  // ####################
  assign lim = ctrl_i.limits;  // index 0 is d0

  always_comb begin
    carry[0] = tick;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      // a digit left above a lowered limit also wraps
      wrap[i] = dig_q[i] >= lim[i];
      if (i > 0) begin
        carry[i] = carry[i-1] & wrap[i-1];
      end
      if (carry[i]) begin
        dig_d[i] = wrap[i] ? '0 : dig_q[i] + 1'b1;
      end else begin
        dig_d[i] = dig_q[i];
      end
    end
  end

  always_ff @(posedge clk100_i or posedge rstn_i) begin
    if (rstn_i) begin
      dig_q <= '0;
    end else begin
      dig_q <= dig_d;  // d3 drops its carry out
    end
  end

  assign digits_o = stw_pkg::stw_digits_t'(dig_q);

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+.
stw_pkg.sv
stw_button_sync.sv
stw_control.sv
stw_time_counter.sv
stw_seg_display.sv
stopwatch.sv
stopwatch_props.sv
tb_stopwatch.sv

// ==== tb_stopwatch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stw_params.svh"

module tb_stopwatch;

  localparam int unsigned TICK_DIV   = 5;
  localparam int unsigned PERIOD     = 40;
  localparam int          BTN_START  = 0;
  localparam int          BTN_SET    = 1;
  localparam int          BTN_CHANGE = 2;

  logic                    clk100;
  logic                    rstn;
  logic                    start_stop;
  logic                    set_btn;
  logic                    change_btn;
  logic [`STW_SEG_W-1:0]   hex0;
  logic [`STW_SEG_W-1:0]   hex1;
  logic [`STW_SEG_W-1:0]   hex2;
  logic [`STW_SEG_W-1:0]   hex3;
  logic [4*`STW_SEG_W-1:0] exp_hex;    // {hex3, hex2, hex1, hex0}
  logic                    check_en;
  logic [15:0]             lim_model;  // d0 in [3:0]
  int                      run_cycles; // cycles with counting enabled since reset
  int                      err_cnt;
  int                      chk_errs;
  int                      test_cnt;
  int                      test_fail;
  int                      seed;

  stopwatch #(
    .tick_div (TICK_DIV)
  ) u_stopwatch (
    .clk100_i     (clk100),
    .rstn_i       (rstn),
    .start_stop_i (start_stop),
    .set_i        (set_btn),
    .change_i     (change_btn),
    .hex0_o       (hex0),
    .hex1_o       (hex1),
    .hex2_o       (hex2),
    .hex3_o       (hex3)
  );

  always #(PERIOD/2) clk100 = ~clk100;

  // ####################
  // reference model
  // ####################
  function automatic logic [`STW_SEG_W-1:0] seg_of(input logic [3:0] bcd);
    case (bcd)
      4'd0:    return 7'b0000001;
      4'd1:    return 7'b1001111;
      4'd2:    return 7'b0010010;
      4'd3:    return 7'b0000110;
      4'd4:    return 7'b1001100;
      4'd5:    return 7'b0100100;
      4'd6:    return 7'b0100000;
      4'd7:    return 7'b0001111;
      4'd8:    return 7'b0000000;
      4'd9:    return 7'b0000100;
      default: return 7'b1111111;
    endcase
  endfunction

  function automatic logic [4*`STW_SEG_W-1:0] ref_hex(input int ticks, input logic [15:0] lim);
    logic [3:0]              d [4];
    logic                    cy;
    logic [4*`STW_SEG_W-1:0] res;
    for (int i = 0; i < 4; i++) begin
      d[i] = '0;
    end
    for (int t = 0; t < ticks; t++) begin
      cy = 1'b1;
      for (int i = 0; i < 4; i++) begin
        if (cy && d[i] == lim[4*i +: 4]) begin
          d[i] = '0;  // wrap and pass the carry up
        end else if (cy) begin
          d[i] = d[i] + 4'd1;
          cy   = 1'b0;
        end
      end
    end
    for (int i = 0; i < 4; i++) begin
      res[`STW_SEG_W*i +: `STW_SEG_W] = seg_of(d[i]);
    end
    return res;
  endfunction

  function automatic logic [3:0] next_limit(input logic [3:0] v);
    return (v == 4'd9) ? 4'd0 : v + 4'd1;
  endfunction

  // ####################
  // comparing process
  // ####################
  task automatic compare_pins();
    assert (hex0 == exp_hex[6:0]) else begin
      $display("[ERROR] %0t ns hex0_o: expected %b, got %b", $time, exp_hex[6:0], hex0);
      chk_errs++;
    end
    assert (hex1 == exp_hex[13:7]) else begin
      $display("[ERROR] %0t ns hex1_o: expected %b, got %b", $time, exp_hex[13:7], hex1);
      chk_errs++;
    end
    assert (hex2 == exp_hex[20:14]) else begin
      $display("[ERROR] %0t ns hex2_o: expected %b, got %b", $time, exp_hex[20:14], hex2);
      chk_errs++;
    end
    assert (hex3 == exp_hex[27:21]) else begin
      $display("[ERROR] %0t ns hex3_o: expected %b, got %b", $time, exp_hex[27:21], hex3);
      chk_errs++;
    end
  endtask

  always @(posedge clk100) begin
    if (check_en) begin
      compare_pins();
    end
  end

  // ####################
  // stimulus
  // ####################
  task automatic drive_btn(input int which, input logic val);
    case (which)
      BTN_START: start_stop = val;
      BTN_SET:   set_btn    = val;
      default:   change_btn = val;
    endcase
  endtask

  task automatic press(input int which);
    drive_btn(which, 1'b1);
    repeat (4) @(negedge clk100);
    drive_btn(which, 1'b0);
    repeat (4) @(negedge clk100);
  endtask

  task automatic apply_reset();
    check_en   = 1'b0;
    rstn       = 1'b1;
    repeat (2) @(negedge clk100);
    rstn       = 1'b0;
    run_cycles = 0;
    lim_model  = 16'h9999;
  endtask

  // equal start and stop latency makes the press gap the run time
  task automatic timed_run(input int cycles);
    press(BTN_START);
    repeat (cycles - 8) @(negedge clk100);
    press(BTN_START);
    run_cycles += cycles;
  endtask

  task automatic program_limits(input logic [15:0] target);
    for (int i = 0; i < 4; i++) begin
      press(BTN_SET);
      for (int n = 0; n < 10 && lim_model[4*i +: 4] != target[4*i +: 4]; n++) begin
        press(BTN_CHANGE);
        lim_model[4*i +: 4] = next_limit(lim_model[4*i +: 4]);
      end
    end
    press(BTN_SET);  // D3 back to idle
  endtask

  task automatic wait_display(input int max_cycles);
    int n;
    n = 0;
    while ({hex3, hex2, hex1, hex0} != exp_hex && n < max_cycles) begin
      @(negedge clk100);
      n++;
    end
    assert ({hex3, hex2, hex1, hex0} == exp_hex) else begin
      $display("display did not reach the expected value within %0d cycles", max_cycles);
      err_cnt++;
    end
  endtask

  task automatic check_display(input int hold);
    exp_hex = ref_hex(run_cycles / TICK_DIV, lim_model);
    wait_display(20);
    check_en = 1'b1;
    repeat (hold) @(negedge clk100);
    check_en = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt + chk_errs == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail++;
      $display("test %0d %s: failed, %0d errors", test_cnt, name,
               err_cnt + chk_errs - errs_before);
    end
  endtask

  initial begin
    int errs;
    int len;
    clk100     = 1'b0;
    start_stop = 1'b0;
    set_btn    = 1'b0;
    change_btn = 1'b0;
    exp_hex    = '0;
    err_cnt    = 0;
    chk_errs   = 0;
    test_cnt   = 0;
    test_fail  = 0;
    seed       = 32'hfa9f;
    apply_reset();

    errs = err_cnt + chk_errs;
    check_display(50);
    finish_test("idle after reset", errs);

    errs = err_cnt + chk_errs;
    len  = 40 + ({$random(seed)} % 361);
    timed_run(len);
    check_display(50);
    finish_test("single run", errs);

    errs = err_cnt + chk_errs;
    for (int r = 0; r < 3; r++) begin
      len = 40 + ({$random(seed)} % 361);
      timed_run(len);
      check_display(5);
    end
    finish_test("accumulated runs", errs);

    apply_reset();
    errs = err_cnt + chk_errs;
    program_limits(16'h1123);
    len = 260 + ({$random(seed)} % 141);  // past the 48 tick wrap
    timed_run(len);
    check_display(50);
    finish_test("custom limits", errs);

    apply_reset();
    errs = err_cnt + chk_errs;
    press(BTN_SET);
    press(BTN_SET);
    for (int n = 0; n < 11; n++) begin
      press(BTN_CHANGE);  // d1 limit goes 0 .. 9 and back to 0
      lim_model[7:4] = next_limit(lim_model[7:4]);
    end
    repeat (3) press(BTN_SET);
    len = 200 + ({$random(seed)} % 201);
    timed_run(len);
    check_display(50);
    finish_test("zero limit", errs);

    errs = err_cnt + chk_errs;
    press(BTN_START);
    repeat (12) @(negedge clk100);
    press(BTN_SET);              // counting freezes in D0
    run_cycles += 20;
    press(BTN_START);            // not a stop while editing
    check_display(50);
    repeat (3) press(BTN_SET);
    press(BTN_SET);              // idle again, the watch runs on
    repeat (32) @(negedge clk100);
    press(BTN_START);
    run_cycles += 40;
    check_display(50);
    finish_test("start/stop in set mode", errs);

    $display("tests: %0d, failed: %0d, errors: %0d", test_cnt, test_fail, err_cnt + chk_errs);
    if (test_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(PERIOD * 50000);
    $display("watchdog expired, simulation did not finish");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
